/* bench/csr_tb_table.svh */
// Columns: {re, we, trap, mret}, op, address, write data, {flags valid, flags},
// {meip, mtip, msip}, expected kind, expected read value
// ====================
// Read/modify/write on mscratch, mtvec, mepc, mie
// ====================
add_row(4'b1100, OP_RW,  CSR_MSCRATCH, 'hF0F01234, 6'h00, 3'b000, K_VAL, 'h00000000);
add_row(4'b1100, OP_RS,  CSR_MSCRATCH, 'h00000F0F, 6'h00, 3'b000, K_VAL, 'hF0F01234);
add_row(4'b1100, OP_RC,  CSR_MSCRATCH, 'hF0000030, 6'h00, 3'b000, K_VAL, 'hF0F01F3F);
add_row(4'b1100, OP_RWI, CSR_MSCRATCH, 'h00000015, 6'h00, 3'b000, K_VAL, 'h00F01F0F);
add_row(4'b1100, OP_RSI, CSR_MSCRATCH, 'h0000000A, 6'h00, 3'b000, K_VAL, 'h00000015);
add_row(4'b1100, OP_RCI, CSR_MSCRATCH, 'h00000003, 6'h00, 3'b000, K_VAL, 'h0000001F);
// Stalled write, commit qualifier low
add_row(4'b1000, OP_RW,  CSR_MSCRATCH, 'hFFFFFFFF, 6'h00, 3'b000, K_VAL, 'h0000001C);
add_row(4'b1000, OP_RS,  CSR_MSCRATCH, 'h00000000, 6'h00, 3'b000, K_VAL, 'h0000001C);
add_row(4'b1100, OP_RW,  CSR_MTVEC,    'h80000103, 6'h00, 3'b000, K_VAL, 'h00000000);
add_row(4'b1000, OP_RS,  CSR_MTVEC,    'h00000000, 6'h00, 3'b000, K_VAL, 'h80000100);
add_row(4'b1100, OP_RW,  CSR_MEPC,     'h00004447, 6'h00, 3'b000, K_VAL, 'h00000000);
add_row(4'b1000, OP_RS,  CSR_MEPC,     'h00000000, 6'h00, 3'b000, K_VAL, 'h00004446);
add_row(4'b1100, OP_RW,  CSR_MIE,      'hFFFFFFFF, 6'h00, 3'b000, K_VAL, 'h00000000);
add_row(4'b1000, OP_RS,  CSR_MIE,      'h00000000, 6'h00, 3'b000, K_VAL, 'h00000888);
// ====================
// Trap entry and MRET
// ====================
add_row(4'b1100, OP_RW,  CSR_MSTATUS,  'h00000008, 6'h00, 3'b000, K_VAL, 'h00000000);
add_row(4'b0010, OP_RW,  CSR_MSTATUS,  'h00000000, 6'h00, 3'b000, K_VAL, 'h00000000);
add_row(4'b1000, OP_RS,  CSR_MSTATUS,  'h00000000, 6'h00, 3'b000, K_VAL, 'h00000080);
add_row(4'b1000, OP_RS,  CSR_MEPC,     'h00000000, 6'h00, 3'b000, K_VAL, 'h00002468);
add_row(4'b1000, OP_RS,  CSR_MCAUSE,   'h00000000, 6'h00, 3'b000, K_VAL, 'h0000000B);
add_row(4'b1000, OP_RS,  CSR_MTVAL,    'h00000000, 6'h00, 3'b000, K_VAL, 'hCAFEF00D);
add_row(4'b0001, OP_RW,  CSR_MSTATUS,  'h00000000, 6'h00, 3'b000, K_VAL, 'h00000000);
add_row(4'b1000, OP_RS,  CSR_MSTATUS,  'h00000000, 6'h00, 3'b000, K_VAL, 'h00000088);
// ====================
// FP flags, forwarding and fcsr
// ====================
add_row(4'b1000, OP_RS,  CSR_FFLAGS,   'h00000000, 6'h21, 3'b000, K_VAL, 'h00000001);
add_row(4'b0000, OP_RS,  CSR_FFLAGS,   'h00000000, 6'h30, 3'b000, K_VAL, 'h00000000);
add_row(4'b1000, OP_RS,  CSR_FFLAGS,   'h00000000, 6'h00, 3'b000, K_VAL, 'h00000011);
add_row(4'b1100, OP_RW,  CSR_FFLAGS,   'h00000004, 6'h22, 3'b000, K_VAL, 'h00000013);
add_row(4'b1000, OP_RS,  CSR_FFLAGS,   'h00000000, 6'h00, 3'b000, K_VAL, 'h00000004);
add_row(4'b1100, OP_RW,  CSR_FCSR,     'h00000088, 6'h00, 3'b000, K_VAL, 'h00000004);
add_row(4'b1000, OP_RS,  CSR_FCSR,     'h00000000, 6'h21, 3'b000, K_VAL, 'h00000089);
add_row(4'b1000, OP_RS,  CSR_FRM,      'h00000000, 6'h00, 3'b000, K_VAL, 'h00000004);
// ====================
// Counters and time
// ====================
add_row(4'b1000, OP_RS,  CSR_CYCLE,    'h00000000, 6'h00, 3'b000, K_CYC, 'h00000000);
add_row(4'b1000, OP_RS,  CSR_CYCLEH,   'h00000000, 6'h00, 3'b000, K_CYCH, 'h00000000);
add_row(4'b1000, OP_RS,  CSR_INSTRET,  'h00000000, 6'h00, 3'b000, K_INS, 'h00000000);
add_row(4'b1000, OP_RS,  CSR_INSTRETH, 'h00000000, 6'h00, 3'b000, K_INSH, 'h00000000);
add_row(4'b1000, OP_RS,  CSR_TIME,     'h00000000, 6'h00, 3'b000, K_TIM, 'h00000000);
add_row(4'b1000, OP_RS,  CSR_TIMEH,    'h00000000, 6'h00, 3'b000, K_TIMH, 'h00000000);
// ====================
// Read-only and unknown addresses
// ====================
add_row(4'b1100, OP_RW,  CSR_MISA,     'h00000000, 6'h00, 3'b000, K_VAL, MISA_VALUE);
add_row(4'b1000, OP_RS,  CSR_MISA,     'h00000000, 6'h00, 3'b000, K_VAL, MISA_VALUE);
add_row(4'b1100, OP_RW,  CSR_MIP,      'hFFFFFFFF, 6'h00, 3'b101, K_VAL, 'h00000808);
add_row(4'b1000, OP_RS,  CSR_MIP,      'h00000000, 6'h00, 3'b010, K_VAL, 'h00000080);
add_row(4'b1000, OP_RS,  CSR_MHARTID,  'h00000000, 6'h00, 3'b000, K_VAL, 'h00000000);
add_row(4'b1100, OP_RW,  12'h7C0,      'h12345678, 6'h00, 3'b000, K_VAL, 'h00000000);
add_row(4'b1000, OP_RS,  12'h7C0,      'h00000000, 6'h00, 3'b000, K_VAL, 'h00000000);

/* bench/csr_file_tb.sv */
`timescale 1ns/1ps

module csr_file_tb;

  import csr_pkg::*;

  localparam int CLK_PERIOD_NS = 8;
  localparam int RST_CYCLES = 3;
  localparam int RANDOM_CYCLES = 40;
  localparam int MAX_ROWS = 64;
  // Fixed trap context, captured on trap entry
  localparam xlen_t TRAP_PC = 32'h0000_2468;
  localparam xlen_t TRAP_CAUSE = 32'h0000_000B;
  localparam xlen_t TRAP_VALUE = 32'hCAFE_F00D;
  // Where a row's expected value comes from
  localparam logic [2:0] K_VAL = 3'd0;
  localparam logic [2:0] K_CYC = 3'd1;
  localparam logic [2:0] K_CYCH = 3'd2;
  localparam logic [2:0] K_INS = 3'd3;
  localparam logic [2:0] K_INSH = 3'd4;
  localparam logic [2:0] K_TIM = 3'd5;
  localparam logic [2:0] K_TIMH = 3'd6;

  typedef struct packed {
    logic [3:0] ctl;
    csr_op_t    op;
    csr_addr_t  addr;
    xlen_t      wdata;
    logic [5:0] fp;
    logic [2:0] irq;
    logic [2:0] kind;
    xlen_t      expected;
  } row_t;

  logic i_clk;
  logic i_rst;
  logic i_csr_read_enable;
  csr_addr_t i_csr_address;
  csr_op_t i_csr_op;
  xlen_t i_csr_write_data;
  logic i_csr_write_enable;
  xlen_t o_csr_read_data;
  logic i_instruction_retired;
  logic i_msip;
  logic i_mtip;
  logic i_meip;
  counter_t i_mtime;
  logic i_trap_taken;
  xlen_t i_trap_pc;
  xlen_t i_trap_cause;
  xlen_t i_trap_value;
  logic i_mret_taken;
  xlen_t o_mstatus;
  xlen_t o_mie;
  xlen_t o_mtvec;
  xlen_t o_mepc;
  fp_flags_t i_fp_flags;
  logic i_fp_flags_valid;
  frm_t o_frm;

  row_t rows [MAX_ROWS];
  int row_count = 0;
  int errors = 0;
  logic [31:0] lfsr_state;
  // Edges since reset release, and retire pulses driven so far
  counter_t edge_count;
  counter_t retire_count;

  csr_file_top dut_i (.*);

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD_NS / 2) i_clk = ~i_clk;
  end

  always @(posedge i_clk) begin
    if (i_rst) begin
      edge_count <= '0;
    end else begin
      edge_count <= edge_count + counter_t'(1);
    end
  end

  // Galois form, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic next_random_bit();
    logic bit_out;
    bit_out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (bit_out) begin
      lfsr_state = lfsr_state ^ 32'h8020_0003;
    end
    return bit_out;
  endfunction

  function automatic counter_t random_count();
    counter_t value;
    value = '0;
    for (int b = 0; b < 64; b++) begin
      value = {value[62:0], next_random_bit()};
    end
    return value;
  endfunction

  task automatic check_value(input string name, input xlen_t actual, input xlen_t expected);
    if (actual !== expected) begin
      errors++;
      $display("[ERROR] t=%0t %s actual=%h expected=%h", $time, name, actual, expected);
      $display("TESTS FAILED");
      $fatal(1, "Stopping at the first mismatch");
    end
  endtask

  task automatic add_row(input logic [3:0] ctl, input csr_op_t op, input csr_addr_t addr,
                         input xlen_t wdata, input logic [5:0] fp, input logic [2:0] irq,
                         input logic [2:0] kind, input xlen_t expected);
    rows[row_count] = {ctl, op, addr, wdata, fp, irq, kind, expected};
    row_count++;
  endtask

  task automatic load_table();
    `include "csr_tb_table.svh"
  endtask

  // Retire pulse drawn last, so instret expectations count earlier pulses only
  task automatic step_retire();
    i_instruction_retired = next_random_bit();
    if (i_instruction_retired) begin
      retire_count = retire_count + counter_t'(1);
    end
  endtask

  task automatic drive_idle();
    {i_csr_read_enable, i_csr_write_enable, i_trap_taken, i_mret_taken} = 4'b0000;
    {i_fp_flags_valid, i_fp_flags} = 6'h00;
    {i_meip, i_mtip, i_msip} = 3'b000;
    i_mtime = random_count();
    step_retire();
  endtask

  task automatic apply_row(input row_t r, output xlen_t expected);
    i_mtime = random_count();
    case (r.kind)
      K_CYC:   expected = edge_count[31:0];
      K_CYCH:  expected = edge_count[63:32];
      K_INS:   expected = retire_count[31:0];
      K_INSH:  expected = retire_count[63:32];
      K_TIM:   expected = i_mtime[31:0];
      K_TIMH:  expected = i_mtime[63:32];
      default: expected = r.expected;
    endcase
    {i_csr_read_enable, i_csr_write_enable, i_trap_taken, i_mret_taken} = r.ctl;
    i_csr_op = r.op;
    i_csr_address = r.addr;
    i_csr_write_data = r.wdata;
    {i_fp_flags_valid, i_fp_flags} = r.fp;
    {i_meip, i_mtip, i_msip} = r.irq;
    step_retire();
  endtask

  // Watchdog sized from reset, random phase and table length
  initial begin
    int limit_cycles;
    wait (row_count > 0);
    limit_cycles = 2 * (RST_CYCLES + RANDOM_CYCLES + row_count + 8);
    #(limit_cycles * CLK_PERIOD_NS);
    $display("Watchdog expired before the table run finished");
    $display("TESTS FAILED");
    $fatal(1, "Timeout");
  end

  initial begin
    xlen_t pending;
    string name;
    i_rst = 1'b1;
    i_csr_read_enable = 1'b0;
    i_csr_address = '0;
    i_csr_op = OP_RW;
    i_csr_write_data = '0;
    i_csr_write_enable = 1'b0;
    i_instruction_retired = 1'b0;
    {i_meip, i_mtip, i_msip} = 3'b000;
    i_mtime = '0;
    i_trap_taken = 1'b0;
    i_trap_pc = TRAP_PC;
    i_trap_cause = TRAP_CAUSE;
    i_trap_value = TRAP_VALUE;
    i_mret_taken = 1'b0;
    {i_fp_flags_valid, i_fp_flags} = 6'h00;
    lfsr_state = 32'h4358;
    retire_count = '0;
    pending = '0;
    load_table();

    repeat (RST_CYCLES) @(posedge i_clk);
    #1;
    i_rst = 1'b0;

    // Random retire and mtime with no access, reads stay zero
    for (int i = 0; i < RANDOM_CYCLES; i++) begin
      @(posedge i_clk);
      #1;
      check_value("o_csr_read_data (idle)", o_csr_read_data, '0);
      drive_idle();
    end

    // One row per cycle, its read data checked after the next edge
    for (int i = 0; i <= row_count; i++) begin
      @(posedge i_clk);
      #1;
      if (i > 0) begin
        name = $sformatf("o_csr_read_data (row %0d)", i - 1);
        check_value(name, o_csr_read_data, pending);
      end
      if (i < row_count) begin
        apply_row(rows[i], pending);
      end else begin
        drive_idle();
      end
    end

    // Direct outputs after the whole table
    check_value("o_frm", xlen_t'(o_frm), 32'h0000_0004);
    check_value("o_mstatus", o_mstatus, 32'h0000_0088);
    check_value("o_mie", o_mie, 32'h0000_0888);
    check_value("o_mtvec", o_mtvec, 32'h8000_0100);
    check_value("o_mepc", o_mepc, TRAP_PC);

    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* design/csr_access_unit.sv */
`timescale 1ns/1ps

module csr_access_unit (
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_csr_read_enable,
  input  csr_pkg::csr_addr_t  i_csr_address,
  input  csr_pkg::csr_op_t    i_csr_op,
  input  csr_pkg::xlen_t      i_csr_write_data,
  input  logic                i_csr_write_enable,
  input  csr_pkg::fp_flags_t  i_fflags,
  input  csr_pkg::fp_flags_t  i_fflags_fwd,
  input  csr_pkg::frm_t       i_frm,
  input  csr_pkg::xlen_t      i_mstatus,
  input  csr_pkg::xlen_t      i_mie,
  input  csr_pkg::xlen_t      i_mtvec,
  input  csr_pkg::xlen_t      i_mscratch,
  input  csr_pkg::xlen_t      i_mepc,
  input  csr_pkg::xlen_t      i_mcause,
  input  csr_pkg::xlen_t      i_mtval,
  input  csr_pkg::counter_t   i_cycle,
  input  csr_pkg::counter_t   i_instret,
  input  csr_pkg::counter_t   i_mtime,
  input  logic                i_msip,
  input  logic                i_mtip,
  input  logic                i_meip,
  output logic                o_wr_en,
  output csr_pkg::xlen_t      o_new_value,
  output csr_pkg::xlen_t      o_csr_read_data
);

  import csr_pkg::*;

  xlen_t fcsr_raw;
  xlen_t fcsr_fwd;
  xlen_t mip;
  xlen_t cur_value;
  xlen_t rd_data_d;

  // Commit only when the instruction is really executing
  assign o_wr_en = i_csr_read_enable & i_csr_write_enable;

  // fcsr views, raw for RMW and forwarded for reads
  always_comb begin
    fcsr_raw = '0;
    fcsr_raw[FCSR_FRM_LSB +: $bits(frm_t)] = i_frm;
    fcsr_raw[FCSR_FRM_LSB-1:0] = i_fflags;
    fcsr_fwd = fcsr_raw;
    fcsr_fwd[FCSR_FRM_LSB-1:0] = i_fflags_fwd;
  end

  // mip mirrors the interrupt lines
  always_comb begin
    mip = '0;
    mip[MIE_MSIE_BIT] = i_msip;
    mip[MIE_MTIE_BIT] = i_mtip;
    mip[MIE_MEIE_BIT] = i_meip;
  end

  // ====================
  // Read-modify-write
  // ====================

  // Current value, writable CSRs only
  always_comb begin
    case (i_csr_address)
      CSR_FFLAGS:   cur_value = xlen_t'(i_fflags);
      CSR_FRM:      cur_value = xlen_t'(i_frm);
      CSR_FCSR:     cur_value = fcsr_raw;
      CSR_MSTATUS:  cur_value = i_mstatus;
      CSR_MIE:      cur_value = i_mie;
      CSR_MTVEC:    cur_value = i_mtvec;
      CSR_MSCRATCH: cur_value = i_mscratch;
      CSR_MEPC:     cur_value = i_mepc;
      CSR_MCAUSE:   cur_value = i_mcause;
      CSR_MTVAL:    cur_value = i_mtval;
      default:      cur_value = '0;
    endcase
  end

  // Register and immediate forms share one rule
  always_comb begin
    case (i_csr_op)
      OP_RW, OP_RWI: o_new_value = i_csr_write_data;
      OP_RS, OP_RSI: o_new_value = cur_value | i_csr_write_data;
      OP_RC, OP_RCI: o_new_value = cur_value & ~i_csr_write_data;
      // Reserved op leaves the CSR unchanged
      default:       o_new_value = cur_value;
    endcase
  end

  // ====================
  // Read path
  // ====================

  always_comb begin
    rd_data_d = '0;
    if (i_csr_read_enable) begin
      case (i_csr_address)
        CSR_FFLAGS:   rd_data_d = xlen_t'(i_fflags_fwd);
        CSR_FRM:      rd_data_d = xlen_t'(i_frm);
        CSR_FCSR:     rd_data_d = fcsr_fwd;
        CSR_CYCLE:    rd_data_d = i_cycle[31:0];
        CSR_CYCLEH:   rd_data_d = i_cycle[63:32];
        CSR_TIME:     rd_data_d = i_mtime[31:0];
        CSR_TIMEH:    rd_data_d = i_mtime[63:32];
        CSR_INSTRET:  rd_data_d = i_instret[31:0];
        CSR_INSTRETH: rd_data_d = i_instret[63:32];
        CSR_MSTATUS:  rd_data_d = i_mstatus;
        CSR_MISA:     rd_data_d = MISA_VALUE;
        CSR_MIE:      rd_data_d = i_mie;
        CSR_MTVEC:    rd_data_d = i_mtvec;
        CSR_MSCRATCH: rd_data_d = i_mscratch;
        CSR_MEPC:     rd_data_d = i_mepc;
        CSR_MCAUSE:   rd_data_d = i_mcause;
        CSR_MTVAL:    rd_data_d = i_mtval;
        CSR_MIP:      rd_data_d = mip;
        // Single hart, always id zero
        CSR_MHARTID:  rd_data_d = '0;
        default:      rd_data_d = '0;
      endcase
    end
  end

  // One cycle of read latency
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_csr_read_data <= '0;
    end else begin
      o_csr_read_data <= rd_data_d;
    end
  end

  // Decode never issues the reserved funct3 as a CSR access
  a_no_rsvd_op : assert property (@(posedge i_clk) disable iff (i_rst)
    i_csr_read_enable |-> (i_csr_op != OP_RSVD));

endmodule

/* design/csr_counters.sv */
`timescale 1ns/1ps

module csr_counters (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_instruction_retired,
  output csr_pkg::counter_t o_cycle,
  output csr_pkg::counter_t o_instret
);

  import csr_pkg::*;

  counter_t cycle_q;
  counter_t instret_q;

  // ====================
  // Cycle counter
  // ====================

  // Free-running, counts every edge after reset
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      cycle_q <= '0;
    end else begin
      cycle_q <= cycle_q + counter_t'(1);
    end
  end

  // ====================
  // Retired instructions
  // ====================

  // One count per retire pulse
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      instret_q <= '0;
    end else if (i_instruction_retired) begin
      instret_q <= instret_q + counter_t'(1);
    end
  end

  // Full 64-bit values, the read mux picks the halves
  assign o_cycle = cycle_q;
  assign o_instret = instret_q;

endmodule

/* design/csr_file_top.sv */
`timescale 1ns/1ps

module csr_file_top (
  input  logic               i_clk,
  input  logic               i_rst,
  // CSR access from the execute stage
  input  logic               i_csr_read_enable,
  input  csr_pkg::csr_addr_t i_csr_address,
  input  csr_pkg::csr_op_t   i_csr_op,
  input  csr_pkg::xlen_t     i_csr_write_data,
  input  logic               i_csr_write_enable,
  output csr_pkg::xlen_t     o_csr_read_data,
  // Retire and interrupt lines
  input  logic               i_instruction_retired,
  input  logic               i_msip,
  input  logic               i_mtip,
  input  logic               i_meip,
  input  csr_pkg::counter_t  i_mtime,
  // Trap unit
  input  logic               i_trap_taken,
  input  csr_pkg::xlen_t     i_trap_pc,
  input  csr_pkg::xlen_t     i_trap_cause,
  input  csr_pkg::xlen_t     i_trap_value,
  input  logic               i_mret_taken,
  output csr_pkg::xlen_t     o_mstatus,
  output csr_pkg::xlen_t     o_mie,
  output csr_pkg::xlen_t     o_mtvec,
  output csr_pkg::xlen_t     o_mepc,
  // FPU
  input  csr_pkg::fp_flags_t i_fp_flags,
  input  logic               i_fp_flags_valid,
  output csr_pkg::frm_t      o_frm
);

  import csr_pkg::*;

  // Write path shared by both register peers
  logic wr_en;
  xlen_t new_value;

  // Values only the access unit needs
  xlen_t mscratch;
  xlen_t mcause;
  xlen_t mtval;
  fp_flags_t fflags;
  fp_flags_t fflags_fwd;
  counter_t cycle;
  counter_t instret;

  // ====================
  // Access unit
  // ====================

  csr_access_unit access_i (
    .i_clk              (i_clk),
    .i_rst              (i_rst),
    .i_csr_read_enable  (i_csr_read_enable),
    .i_csr_address      (i_csr_address),
    .i_csr_op           (i_csr_op),
    .i_csr_write_data   (i_csr_write_data),
    .i_csr_write_enable (i_csr_write_enable),
    .i_fflags           (fflags),
    .i_fflags_fwd       (fflags_fwd),
    .i_frm              (o_frm),
    .i_mstatus          (o_mstatus),
    .i_mie              (o_mie),
    .i_mtvec            (o_mtvec),
    .i_mscratch         (mscratch),
    .i_mepc             (o_mepc),
    .i_mcause           (mcause),
    .i_mtval            (mtval),
    .i_cycle            (cycle),
    .i_instret          (instret),
    .i_mtime            (i_mtime),
    .i_msip             (i_msip),
    .i_mtip             (i_mtip),
    .i_meip             (i_meip),
    .o_wr_en            (wr_en),
    .o_new_value        (new_value),
    .o_csr_read_data    (o_csr_read_data)
  );

  // ====================
  // Register peers
  // ====================

  csr_counters counters_i (
    .i_clk                 (i_clk),
    .i_rst                 (i_rst),
    .i_instruction_retired (i_instruction_retired),
    .o_cycle               (cycle),
    .o_instret             (instret)
  );

  csr_machine_regs machine_i (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_wr_en       (wr_en),
    .i_csr_address (i_csr_address),
    .i_new_value   (new_value),
    .i_trap_taken  (i_trap_taken),
    .i_trap_pc     (i_trap_pc),
    .i_trap_cause  (i_trap_cause),
    .i_trap_value  (i_trap_value),
    .i_mret_taken  (i_mret_taken),
    .o_mstatus     (o_mstatus),
    .o_mie         (o_mie),
    .o_mtvec       (o_mtvec),
    .o_mscratch    (mscratch),
    .o_mepc        (o_mepc),
    .o_mcause      (mcause),
    .o_mtval       (mtval)
  );

  csr_fp_regs fp_i (
    .i_clk            (i_clk),
    .i_rst            (i_rst),
    .i_wr_en          (wr_en),
    .i_csr_address    (i_csr_address),
    .i_new_value      (new_value),
    .i_fp_flags       (i_fp_flags),
    .i_fp_flags_valid (i_fp_flags_valid),
    .o_fflags         (fflags),
    .o_fflags_fwd     (fflags_fwd),
    .o_frm            (o_frm)
  );

endmodule

/* design/csr_fp_regs.sv */
`timescale 1ns/1ps

module csr_fp_regs (
  input  logic               i_clk,
  input  logic               i_rst,
  input  logic               i_wr_en,
  input  csr_pkg::csr_addr_t i_csr_address,
  input  csr_pkg::xlen_t     i_new_value,
  input  csr_pkg::fp_flags_t i_fp_flags,
  input  logic               i_fp_flags_valid,
  output csr_pkg::fp_flags_t o_fflags,
  output csr_pkg::fp_flags_t o_fflags_fwd,
  output csr_pkg::frm_t      o_frm
);

  import csr_pkg::*;

  logic fp_wr;
  fp_flags_t new_flags;

  // Any write that touches fflags or frm
  assign fp_wr = i_wr_en &&
                 ((i_csr_address == CSR_FFLAGS) ||
                  (i_csr_address == CSR_FRM) ||
                  (i_csr_address == CSR_FCSR));

  // Flags retiring from writeback this cycle
  assign new_flags = i_fp_flags_valid ? i_fp_flags : '0;

  // ====================
  // fflags and frm
  // ====================

  // CSR write beats accumulation
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_fflags <= '0;
      // Round to nearest even
      o_frm <= '0;
    end else if (fp_wr) begin
      case (i_csr_address)
        CSR_FFLAGS: o_fflags <= i_new_value[$bits(fp_flags_t)-1:0];
        CSR_FRM:    o_frm <= i_new_value[$bits(frm_t)-1:0];
        default: begin
          // fcsr carries both fields
          o_fflags <= i_new_value[FCSR_FRM_LSB-1:0];
          o_frm <= i_new_value[FCSR_FRM_LSB +: $bits(frm_t)];
        end
      endcase
    end else begin
      // Sticky, cleared only by software
      o_fflags <= o_fflags | new_flags;
    end
  end

  // Same-cycle view for reads of fflags and fcsr
  assign o_fflags_fwd = o_fflags | new_flags;

endmodule

/* design/csr_machine_regs.sv */
`timescale 1ns/1ps

module csr_machine_regs (
  input  logic               i_clk,
  input  logic               i_rst,
  input  logic               i_wr_en,
  input  csr_pkg::csr_addr_t i_csr_address,
  input  csr_pkg::xlen_t     i_new_value,
  input  logic               i_trap_taken,
  input  csr_pkg::xlen_t     i_trap_pc,
  input  csr_pkg::xlen_t     i_trap_cause,
  input  csr_pkg::xlen_t     i_trap_value,
  input  logic               i_mret_taken,
  output csr_pkg::xlen_t     o_mstatus,
  output csr_pkg::xlen_t     o_mie,
  output csr_pkg::xlen_t     o_mtvec,
  output csr_pkg::xlen_t     o_mscratch,
  output csr_pkg::xlen_t     o_mepc,
  output csr_pkg::xlen_t     o_mcause,
  output csr_pkg::xlen_t     o_mtval
);

  import csr_pkg::*;

  // Implemented mstatus bits
  logic mstatus_mie;
  logic mstatus_mpie;
  // Implemented mie bits
  logic mie_msie;
  logic mie_mtie;
  logic mie_meie;

  // Write strobes per register
  logic wr_mstatus;
  logic wr_mie;
  logic wr_mtvec;
  logic wr_mscratch;
  logic wr_mepc;
  logic wr_mcause;
  logic wr_mtval;

  assign wr_mstatus = i_wr_en && (i_csr_address == CSR_MSTATUS);
  assign wr_mie = i_wr_en && (i_csr_address == CSR_MIE);
  assign wr_mtvec = i_wr_en && (i_csr_address == CSR_MTVEC);
  assign wr_mscratch = i_wr_en && (i_csr_address == CSR_MSCRATCH);
  assign wr_mepc = i_wr_en && (i_csr_address == CSR_MEPC);
  assign wr_mcause = i_wr_en && (i_csr_address == CSR_MCAUSE);
  assign wr_mtval = i_wr_en && (i_csr_address == CSR_MTVAL);

  // ====================
  // mstatus and mie
  // ====================

  // Trap wins over MRET, MRET wins over a CSR write
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      mstatus_mie <= 1'b0;
      mstatus_mpie <= 1'b0;
    end else if (i_trap_taken) begin
      // Stack MIE into MPIE and mask interrupts
      mstatus_mpie <= mstatus_mie;
      mstatus_mie <= 1'b0;
    end else if (i_mret_taken) begin
      // Pop the stacked enable
      mstatus_mie <= mstatus_mpie;
      mstatus_mpie <= 1'b1;
    end else if (wr_mstatus) begin
      mstatus_mie <= i_new_value[MSTATUS_MIE_BIT];
      mstatus_mpie <= i_new_value[MSTATUS_MPIE_BIT];
    end
  end

  // Only the three M-mode enables are implemented
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      mie_msie <= 1'b0;
      mie_mtie <= 1'b0;
      mie_meie <= 1'b0;
    end else if (wr_mie) begin
      mie_msie <= i_new_value[MIE_MSIE_BIT];
      mie_mtie <= i_new_value[MIE_MTIE_BIT];
      mie_meie <= i_new_value[MIE_MEIE_BIT];
    end
  end

  // ====================
  // Trap state words
  // ====================

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_mtvec <= '0;
      o_mscratch <= '0;
      o_mepc <= '0;
      o_mcause <= '0;
      o_mtval <= '0;
    end else begin
      // Vector base, mode bits forced to direct
      if (wr_mtvec) begin
        o_mtvec <= {i_new_value[31:2], 2'b00};
      end
      if (wr_mscratch) begin
        o_mscratch <= i_new_value;
      end
      if (i_trap_taken) begin
        // Capture the faulting context
        o_mepc <= i_trap_pc;
        o_mcause <= i_trap_cause;
        o_mtval <= i_trap_value;
      end else begin
        // Halfword aligned for compressed code
        if (wr_mepc) begin
          o_mepc <= {i_new_value[31:1], 1'b0};
        end
        if (wr_mcause) begin
          o_mcause <= i_new_value;
        end
        if (wr_mtval) begin
          o_mtval <= i_new_value;
        end
      end
    end
  end

  // Architectural views, unimplemented bits read zero
  always_comb begin
    o_mstatus = '0;
    o_mstatus[MSTATUS_MIE_BIT] = mstatus_mie;
    o_mstatus[MSTATUS_MPIE_BIT] = mstatus_mpie;
    o_mie = '0;
    o_mie[MIE_MSIE_BIT] = mie_msie;
    o_mie[MIE_MTIE_BIT] = mie_mtie;
    o_mie[MIE_MEIE_BIT] = mie_meie;
  end

  // Trap unit never enters and returns in the same cycle
  a_trap_mret_excl : assert property (@(posedge i_clk) disable iff (i_rst)
    !(i_trap_taken && i_mret_taken));

endmodule

/* design/csr_pkg.sv */
package csr_pkg;

  // ====================
  // Widths
  // ====================

  // One register word
  typedef logic [31:0] xlen_t;
  // CSR address field of the instruction
  typedef logic [11:0] csr_addr_t;
  // CSR operation, taken straight from funct3
  typedef logic [2:0] csr_op_t;
  // Counter and timer values
  typedef logic [63:0] counter_t;
  // FP exception flags, ordered NV DZ OF UF NX from msb down
  typedef logic [4:0] fp_flags_t;
  // FP rounding mode
  typedef logic [2:0] frm_t;

  // ====================
  // CSR addresses
  // ====================

  // Floating-point CSRs
  localparam csr_addr_t CSR_FFLAGS = 12'h001;
  localparam csr_addr_t CSR_FRM = 12'h002;
  localparam csr_addr_t CSR_FCSR = 12'h003;

  // Zicntr read-only counters, low halves then high halves
  localparam csr_addr_t CSR_CYCLE = 12'hC00;
  localparam csr_addr_t CSR_TIME = 12'hC01;
  localparam csr_addr_t CSR_INSTRET = 12'hC02;
  localparam csr_addr_t CSR_CYCLEH = 12'hC80;
  localparam csr_addr_t CSR_TIMEH = 12'hC81;
  localparam csr_addr_t CSR_INSTRETH = 12'hC82;

  // Machine-level CSRs
  localparam csr_addr_t CSR_MSTATUS = 12'h300;
  localparam csr_addr_t CSR_MISA = 12'h301;
  localparam csr_addr_t CSR_MIE = 12'h304;
  localparam csr_addr_t CSR_MTVEC = 12'h305;
  localparam csr_addr_t CSR_MSCRATCH = 12'h340;
  localparam csr_addr_t CSR_MEPC = 12'h341;
  localparam csr_addr_t CSR_MCAUSE = 12'h342;
  localparam csr_addr_t CSR_MTVAL = 12'h343;
  localparam csr_addr_t CSR_MIP = 12'h344;
  localparam csr_addr_t CSR_MHARTID = 12'hF14;

  // ====================
  // Zicsr operations
  // ====================

  localparam csr_op_t OP_RW = 3'b001;
  localparam csr_op_t OP_RS = 3'b010;
  localparam csr_op_t OP_RC = 3'b011;
  // Reserved encoding in the SYSTEM opcode space
  localparam csr_op_t OP_RSVD = 3'b100;
  localparam csr_op_t OP_RWI = 3'b101;
  localparam csr_op_t OP_RSI = 3'b110;
  localparam csr_op_t OP_RCI = 3'b111;

  // ====================
  // Bit positions
  // ====================

  localparam int MSTATUS_MIE_BIT = 3;
  localparam int MSTATUS_MPIE_BIT = 7;
  // Same positions are used by mip
  localparam int MIE_MSIE_BIT = 3;
  localparam int MIE_MTIE_BIT = 7;
  localparam int MIE_MEIE_BIT = 11;
  // frm sits above fflags inside fcsr
  localparam int FCSR_FRM_LSB = 5;

  // MXL=1 for RV32, extension bits A B F I M
  localparam xlen_t MISA_VALUE = 32'h4000_1123;

endpackage

/* project.f */
+incdir+bench
design/csr_pkg.sv
design/csr_access_unit.sv
design/csr_counters.sv
design/csr_machine_regs.sv
design/csr_fp_regs.sv
design/csr_file_top.sv
bench/csr_file_tb.sv
